/* verilog/rdmat_pkg.sv */
// sizes fixed for a four-entry write buffer; changing N_ENTRIES also needs ENTRY_W updated by hand

//////////////////////////////////////////////////
// shared sizes and vector types for the
// DMA write buffer tracking logic
//////////////////////////////////////////////////

package rdmat_pkg;

   // number of write buffer entries in this tag slice
   localparam int N_ENTRIES = 4;

   // encoded entry index width
   // must cover N_ENTRIES
   localparam int ENTRY_W = 2;

   // miss-buffer id width, from mbctl
   localparam int MBID_W = 4;

   // one bit per entry
   // valid, dram req, acked, cam match, wordlines
   typedef logic [N_ENTRIES-1:0] entry_vec_t;

   // encoded entry number
   // used for the s1 write pick and the c3 evict index
   typedef logic [ENTRY_W-1:0] entry_idx_t;

   // dependent miss-buffer entry
   typedef logic [MBID_W-1:0] mbid_t;

endpackage

/* verilog/rdmat_entry_ctl.sv */
// when every entry is valid the s1 pick reads 0 with an empty wordline; snpctl must not write then

module rdmat_entry_ctl import rdmat_pkg::*; (
   input  logic       rclk,
   input  logic       rst_n,

   // write strobe for the wordline picked last cycle
   input  logic       rdmatag_wr_en_s2,

   // clear wins over any set in the same cycle
   input  entry_vec_t reset_rdmat_vld,
   input  entry_vec_t set_rdmat_acked,

   // evict index arrives in c3, strobe in c4
   input  entry_idx_t rdma_entry_c3,
   input  logic       rdma_ev_en_c4,

   output entry_idx_t rdmat_wr_entry_s1,
   output entry_vec_t rdmat_wr_wl_s2,
   output entry_vec_t rdma_valid,
   output entry_vec_t rdma_dram_req,
   output entry_vec_t rdma_acked,
   output logic       or_rdmat_valid
);

   // one-hot lowest free entry
   entry_vec_t wr_ptr_s1;

   // evict entry index registered from c3 into c4
   entry_idx_t rdma_entry_c4;
   entry_vec_t ev_dram_c4;

   // next-state terms
   entry_vec_t valid_nxt;
   entry_vec_t dram_req_nxt;
   entry_vec_t acked_nxt;

   //////////////////////////////////////////////////
   // write pointer
   //////////////////////////////////////////////////

   // scan from the top down so the lowest free entry is left
   // all valid leaves the pointer empty and index 0
   always_comb begin
      wr_ptr_s1         = '0;
      rdmat_wr_entry_s1 = '0;
      for (int i = N_ENTRIES - 1; i >= 0; i--) begin
         if (!rdma_valid[i]) begin
            wr_ptr_s1         = '0;
            wr_ptr_s1[i]      = 1'b1;
            rdmat_wr_entry_s1 = entry_idx_t'(i);
         end
      end
   end

   // s2 wordline to tag and data arrays
   // plain pipeline of the s1 pick
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rdmat_wr_wl_s2 <= '0;
      end else begin
         rdmat_wr_wl_s2 <= wr_ptr_s1;
      end
   end

   //////////////////////////////////////////////////
   // evict index into c4
   //////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rdma_entry_c4 <= '0;
      end else begin
         rdma_entry_c4 <= rdma_entry_c3;
      end
   end

   // decode to a per-entry set
   // only when tagctl flags a completed wr64
   assign ev_dram_c4 = rdma_ev_en_c4 ? (entry_vec_t'(1) << rdma_entry_c4) : '0;

   //////////////////////////////////////////////////
   // per-entry status bits
   //////////////////////////////////////////////////

   // valid
   // set in s2 on the picked wordline, cleared after evict data drains
   assign valid_nxt = ((rdmat_wr_wl_s2 & {N_ENTRIES{rdmatag_wr_en_s2}}) | rdma_valid)
                      & ~reset_rdmat_vld;

   // dram req
   // entry is ready to go out to dram
   assign dram_req_nxt = (rdma_dram_req | ev_dram_c4) & ~reset_rdmat_vld;

   // acked by the dram controller
   // cleared along with valid
   assign acked_nxt = (rdma_acked | set_rdmat_acked) & ~reset_rdmat_vld;

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rdma_valid    <= '0;
         rdma_dram_req <= '0;
         rdma_acked    <= '0;
      end else begin
         rdma_valid    <= valid_nxt;
         rdma_dram_req <= dram_req_nxt;
         rdma_acked    <= acked_nxt;
      end
   end

   // any entry waiting on dram, to wbctl
   assign or_rdmat_valid = |rdma_dram_req;

endmodule

/* verilog/rdmat_hit_pipe.sv */
// fixed c2 to c4 pipe with no stall; the hit vector in c4 is only meaningful with its qualifier

module rdmat_hit_pipe import rdmat_pkg::*; (
   input  logic       rclk,
   input  logic       rst_n,

   input  entry_vec_t rdmat_cam_match_c2,
   input  entry_vec_t rdma_valid,
   input  entry_vec_t rdma_dram_req,
   input  entry_vec_t rdma_acked,

   // arbctl strobes
   input  logic       inst_vld_c2,
   input  logic       hit_off_c1,

   // miss buffer hit for the same instruction
   input  logic       mbctl_hit_c4,

   output logic       rdmatctl_hit_unqual_c2,
   output entry_vec_t hit_vec_c4,
   output logic       mbid_wr_en_c4
);

   logic       hit_off_c2;
   entry_vec_t hit_vec_c2;
   entry_vec_t hit_vec_c3;
   logic       hit_qual_c2;
   logic       hit_qual_c3;
   logic       hit_qual_c4;

   //////////////////////////////////////////////////
   // c2 hit
   //////////////////////////////////////////////////

   // hit-off lines up with the c2 cam result
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         hit_off_c2 <= 1'b0;
      end else begin
         hit_off_c2 <= hit_off_c1;
      end
   end

   // entry hits only when valid, issued to dram and still unacked
   // an acked entry is on its way out, so no new dependant
   assign hit_vec_c2 = rdmat_cam_match_c2 & rdma_valid & rdma_dram_req
                       & ~(rdma_acked | {N_ENTRIES{hit_off_c2}});

   assign rdmatctl_hit_unqual_c2 = |hit_vec_c2;

   // mbctl gets the unqualified term
   // the mbid write needs a real instruction
   assign hit_qual_c2 = rdmatctl_hit_unqual_c2 & inst_vld_c2;

   //////////////////////////////////////////////////
   // c3 and c4 stages
   //////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         hit_vec_c3  <= '0;
         hit_vec_c4  <= '0;
         hit_qual_c3 <= 1'b0;
         hit_qual_c4 <= 1'b0;
      end else begin
         hit_vec_c3  <= hit_vec_c2;
         hit_vec_c4  <= hit_vec_c3;
         hit_qual_c3 <= hit_qual_c2;
         hit_qual_c4 <= hit_qual_c3;
      end
   end

   // mb hit means the instruction already depends on a miss buffer entry
   assign mbid_wr_en_c4 = hit_qual_c4 & ~mbctl_hit_c4;

endmodule

/* verilog/rdmat_mbid_file.sv */
// assumes at most one acked entry waits on a dependant at a time; all selected mbid-valid bits clear together

module rdmat_mbid_file import rdmat_pkg::*; (
   input  logic       rclk,
   input  logic       rst_n,

   // c4 write from the hit pipe
   input  entry_vec_t hit_vec_c4,
   input  logic       mbid_wr_en_c4,
   input  mbid_t      mbid_c4,

   // status from the controller
   input  entry_vec_t rdma_acked,
   input  entry_vec_t rdma_dram_req,

   // wakeup to mbctl
   output logic       rdmatctl_mbctl_dep_rdy_en,
   output mbid_t      rdmatctl_mbctl_dep_mbid,

   // evict pick to wbctl
   output entry_vec_t rdmat_pick_vec
);

   // per-entry dependent mbid
   mbid_t      mbid_q [N_ENTRIES];
   entry_vec_t mbid_vld;
   entry_vec_t mbid_vld_nxt;

   entry_vec_t sel_insert_c4;
   entry_vec_t sel_mbid;
   logic       or_mbid_vld;

   //////////////////////////////////////////////////
   // mbid write in c4
   //////////////////////////////////////////////////

   assign sel_insert_c4 = hit_vec_c4 & {N_ENTRIES{mbid_wr_en_c4}};

   // hit entries take the c4 mbid
   always_ff @(posedge rclk) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (sel_insert_c4[i]) begin
            mbid_q[i] <= mbid_c4;
         end
      end
   end

   //////////////////////////////////////////////////
   // wakeup select
   //////////////////////////////////////////////////

   // acked and waiting
   // the ack may land while the hit is still in c2..c4,
   // in which case the wakeup comes once mbid_vld sets
   assign sel_mbid = rdma_acked & mbid_vld;

   assign rdmatctl_mbctl_dep_rdy_en = |sel_mbid;

   // lowest selected among the lower entries
   // top entry is the default leg of the mux
   always_comb begin
      rdmatctl_mbctl_dep_mbid = mbid_q[N_ENTRIES-1];
      for (int i = N_ENTRIES - 2; i >= 0; i--) begin
         if (sel_mbid[i]) begin
            rdmatctl_mbctl_dep_mbid = mbid_q[i];
         end
      end
   end

   // set on insert, drop once woken
   assign mbid_vld_nxt = (mbid_vld | sel_insert_c4) & ~sel_mbid;

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         mbid_vld <= '0;
      end else begin
         mbid_vld <= mbid_vld_nxt;
      end
   end

   //////////////////////////////////////////////////
   // evict pick
   //////////////////////////////////////////////////

   // entries with a waiting miss go to dram first
   assign or_mbid_vld = |(rdma_dram_req & mbid_vld);

   assign rdmat_pick_vec = or_mbid_vld ? mbid_vld : rdma_dram_req;

endmodule

/* verilog/rdmat_top.sv */
// all strobes are single-cycle with no back-pressure; reset is synchronous and must span a clock edge

//////////////////////////////////////////////////
// rdma write buffer tracking, top level
// controller plus hit pipe plus mbid file
//////////////////////////////////////////////////

module rdmat_top import rdmat_pkg::*; (
   input  logic       rclk,
   input  logic       rst_n,

   // allocation, from snpctl
   input  logic       rdmatag_wr_en_s2,

   // entry status updates, from wbctl
   input  entry_vec_t reset_rdmat_vld,
   input  entry_vec_t set_rdmat_acked,

   // eviction request, from arb and tagctl
   input  entry_idx_t rdma_entry_c3,
   input  logic       rdma_ev_en_c4,

   // cam lookup and pipe qualifiers
   input  entry_vec_t rdmat_cam_match_c2,
   input  logic       inst_vld_c2,
   input  logic       hit_off_c1,

   // miss buffer side
   input  logic       mbctl_hit_c4,
   input  mbid_t      mbid_c4,

   // to snpctl
   output entry_idx_t rdmat_wr_entry_s1,
   output entry_vec_t rdmat_wr_wl_s2,

   // to wbctl
   output logic       or_rdmat_valid,
   output entry_vec_t rdmat_pick_vec,

   // to mbctl
   output logic       rdmatctl_hit_unqual_c2,
   output logic       rdmatctl_mbctl_dep_rdy_en,
   output mbid_t      rdmatctl_mbctl_dep_mbid
);

   // per-entry status from the controller
   entry_vec_t rdma_valid;
   entry_vec_t rdma_dram_req;
   entry_vec_t rdma_acked;

   // c4 hit info into the mbid file
   entry_vec_t hit_vec_c4;
   logic       mbid_wr_en_c4;

   // status bits and write pointer
   rdmat_entry_ctl entry_ctl_i (
      .rclk              (rclk),
      .rst_n             (rst_n),
      .rdmatag_wr_en_s2  (rdmatag_wr_en_s2),
      .reset_rdmat_vld   (reset_rdmat_vld),
      .set_rdmat_acked   (set_rdmat_acked),
      .rdma_entry_c3     (rdma_entry_c3),
      .rdma_ev_en_c4     (rdma_ev_en_c4),
      .rdmat_wr_entry_s1 (rdmat_wr_entry_s1),
      .rdmat_wr_wl_s2    (rdmat_wr_wl_s2),
      .rdma_valid        (rdma_valid),
      .rdma_dram_req     (rdma_dram_req),
      .rdma_acked        (rdma_acked),
      .or_rdmat_valid    (or_rdmat_valid)
   );

   // c2 hit and pipe to c4
   rdmat_hit_pipe hit_pipe_i (
      .rclk                   (rclk),
      .rst_n                  (rst_n),
      .rdmat_cam_match_c2     (rdmat_cam_match_c2),
      .rdma_valid             (rdma_valid),
      .rdma_dram_req          (rdma_dram_req),
      .rdma_acked             (rdma_acked),
      .inst_vld_c2            (inst_vld_c2),
      .hit_off_c1             (hit_off_c1),
      .mbctl_hit_c4           (mbctl_hit_c4),
      .rdmatctl_hit_unqual_c2 (rdmatctl_hit_unqual_c2),
      .hit_vec_c4             (hit_vec_c4),
      .mbid_wr_en_c4          (mbid_wr_en_c4)
   );

   // dependent mbid storage, wakeup and evict pick
   rdmat_mbid_file mbid_file_i (
      .rclk                      (rclk),
      .rst_n                     (rst_n),
      .hit_vec_c4                (hit_vec_c4),
      .mbid_wr_en_c4             (mbid_wr_en_c4),
      .mbid_c4                   (mbid_c4),
      .rdma_acked                (rdma_acked),
      .rdma_dram_req             (rdma_dram_req),
      .rdmatctl_mbctl_dep_rdy_en (rdmatctl_mbctl_dep_rdy_en),
      .rdmatctl_mbctl_dep_mbid   (rdmatctl_mbctl_dep_mbid),
      .rdmat_pick_vec            (rdmat_pick_vec)
   );

endmodule

/* bench/rdmat_tb.sv */
// vectors come from bench/rdmat_stim.txt, opened relative to the project root; at most MAX_LINES lines

module rdmat_tb import rdmat_pkg::*; ();

   // line limit for the vector loop, cycle limit for the reset wait
   localparam int MAX_LINES   = 200;
   localparam int RST_TIMEOUT = 10;
   localparam int N_FIELDS    = 18;

   logic       rclk;
   logic       rst_n;

   // dut inputs
   logic       rdmatag_wr_en_s2;
   entry_vec_t reset_rdmat_vld;
   entry_vec_t set_rdmat_acked;
   entry_idx_t rdma_entry_c3;
   logic       rdma_ev_en_c4;
   entry_vec_t rdmat_cam_match_c2;
   logic       inst_vld_c2;
   logic       hit_off_c1;
   logic       mbctl_hit_c4;
   mbid_t      mbid_c4;

   // dut outputs
   entry_idx_t rdmat_wr_entry_s1;
   entry_vec_t rdmat_wr_wl_s2;
   logic       or_rdmat_valid;
   entry_vec_t rdmat_pick_vec;
   logic       rdmatctl_hit_unqual_c2;
   logic       rdmatctl_mbctl_dep_rdy_en;
   mbid_t      rdmatctl_mbctl_dep_mbid;

   // one parsed vector of 10 inputs, 7 expected outputs and the check mask
   logic [31:0] fld [N_FIELDS];
   int          vec_idx;
   int          mismatch_cnt;
   int          other_cnt;

   rdmat_top dut_i (.*);

   //////////////////////////////////////////////////
   // clock and reset
   //////////////////////////////////////////////////

   initial rclk = 1'b0;
   always #50 rclk = ~rclk;

   // two edges in reset then released with the input timing
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge rclk);
      #10;
      rst_n = 1'b1;
   end

   //////////////////////////////////////////////////
   // drive and compare helpers
   //////////////////////////////////////////////////

   task automatic drive_idle();
      rdmatag_wr_en_s2   = 1'b0;
      reset_rdmat_vld    = '0;
      set_rdmat_acked    = '0;
      rdma_entry_c3      = '0;
      rdma_ev_en_c4      = 1'b0;
      rdmat_cam_match_c2 = '0;
      inst_vld_c2        = 1'b0;
      hit_off_c1         = 1'b0;
      mbctl_hit_c4       = 1'b0;
      mbid_c4            = '0;
   endtask

   // input columns 0..9 in port order
   task automatic apply_inputs();
      rdmatag_wr_en_s2   = fld[0][0];
      reset_rdmat_vld    = fld[1][N_ENTRIES-1:0];
      set_rdmat_acked    = fld[2][N_ENTRIES-1:0];
      rdma_entry_c3      = fld[3][ENTRY_W-1:0];
      rdma_ev_en_c4      = fld[4][0];
      rdmat_cam_match_c2 = fld[5][N_ENTRIES-1:0];
      inst_vld_c2        = fld[6][0];
      hit_off_c1         = fld[7][0];
      mbctl_hit_c4       = fld[8][0];
      mbid_c4            = fld[9][MBID_W-1:0];
   endtask

   // x or z on the dut side counts as a mismatch
   task automatic compare_field(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      assert (act === exp) else begin
         $display("MISMATCH %s expected 0x%0h got 0x%0h at vector %0d",
                  name, exp, act, vec_idx);
         mismatch_cnt++;
      end
   endtask

   // mask bit n enables expected column 10+n
   // dep_mbid only masked in while dep_rdy_en is expected high
   task automatic check_outputs();
      logic [6:0] mask;
      mask = fld[17][6:0];
      if (mask[0]) compare_field("rdmat_wr_entry_s1", fld[10], 32'(rdmat_wr_entry_s1));
      if (mask[1]) compare_field("rdmat_wr_wl_s2", fld[11], 32'(rdmat_wr_wl_s2));
      if (mask[2]) compare_field("or_rdmat_valid", fld[12], 32'(or_rdmat_valid));
      if (mask[3]) compare_field("rdmat_pick_vec", fld[13], 32'(rdmat_pick_vec));
      if (mask[4]) compare_field("rdmatctl_hit_unqual_c2", fld[14],
                                 32'(rdmatctl_hit_unqual_c2));
      if (mask[5]) compare_field("rdmatctl_mbctl_dep_rdy_en", fld[15],
                                 32'(rdmatctl_mbctl_dep_rdy_en));
      if (mask[6]) compare_field("rdmatctl_mbctl_dep_mbid", fld[16],
                                 32'(rdmatctl_mbctl_dep_mbid));
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      int    fd;
      int    code;
      int    n_read;
      int    cycles;
      logic  done;
      string line_s;

      drive_idle();
      mismatch_cnt = 0;
      other_cnt    = 0;
      vec_idx      = 0;
      fd           = 0;
      done         = 1'b0;

      // wait for reset release
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
         @(posedge rclk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         $display("ERROR: reset still asserted after %0d cycles", RST_TIMEOUT);
         other_cnt++;
      end else begin
         fd = $fopen("bench/rdmat_stim.txt", "r");
         if (fd == 0) begin
            $display("ERROR: could not open the stimulus file");
            other_cnt++;
         end
      end

      // one vector per cycle
      // drive 10 after the edge, sample 10 before the next one
      cycles = 0;
      while (fd != 0 && !done && cycles < MAX_LINES) begin
         cycles++;
         code = $fgets(line_s, fd);
         if (code == 0) begin
            done = 1'b1;
         end else if (line_s.len() > 1 && line_s.getc(0) != 8'h23) begin
            // lines starting with # hold the column legend
            n_read = $sscanf(line_s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                             fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                             fld[13], fld[14], fld[15], fld[16], fld[17]);
            if (n_read != N_FIELDS) begin
               $display("ERROR: line after vector %0d has %0d fields instead of %0d",
                        vec_idx, n_read, N_FIELDS);
               other_cnt++;
            end else begin
               @(posedge rclk);
               #10;
               apply_inputs();
               #80;
               check_outputs();
               vec_idx++;
            end
         end
      end
      if (fd != 0) begin
         if (!done) begin
            $display("ERROR: stimulus file not finished within %0d lines", MAX_LINES);
            other_cnt++;
         end
         $fclose(fd);
      end
      if (vec_idx == 0) begin
         $display("ERROR: no vectors were applied");
         other_cnt++;
      end

      $display("errors: %0d mismatches, %0d other failures over %0d vectors",
               mismatch_cnt, other_cnt, vec_idx);
      if (mismatch_cnt + other_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* bench/rdmat_stim.txt */
# in:  wr_en_s2 rst_vld set_acked entry_c3 ev_en_c4 cam_c2 inst_vld_c2 hit_off_c1 mbctl_hit_c4 mbid_c4
# exp: wr_entry_s1 wr_wl_s2 or_valid pick_vec hit_unqual dep_rdy_en dep_mbid, then check mask (hex)
0 0 0 0 0 0 0 0 0 0   0 1 0 0 0 0 0   3f
1 0 0 0 0 0 0 0 0 0   0 1 0 0 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   1 1 0 0 0 0 0   3f
1 0 0 0 0 0 0 0 0 0   1 2 0 0 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   2 2 0 0 0 0 0   3f
1 0 0 0 0 0 0 0 0 0   2 4 0 0 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   3 4 0 0 0 0 0   3f
1 0 0 0 0 0 0 0 0 0   3 8 0 0 0 0 0   3f
0 0 0 1 0 0 0 0 0 0   0 8 0 0 0 0 0   3f
0 0 0 2 1 0 0 0 0 0   0 0 0 0 0 0 0   3f
0 0 0 1 1 0 0 0 0 0   0 0 1 2 0 0 0   3f
0 2 2 0 1 0 0 0 0 0   0 0 1 6 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   1 0 1 4 0 0 0   3f
1 0 0 0 0 0 0 0 0 0   1 2 1 4 0 0 0   3f
0 0 0 0 0 4 1 0 0 0   0 2 1 4 1 0 0   3f
0 0 0 0 0 1 1 1 0 0   0 0 1 4 0 0 0   3f
0 0 0 0 0 4 1 0 0 a   0 0 1 4 0 0 0   3f
0 0 4 0 0 0 0 0 0 0   0 0 1 4 0 0 0   3f
0 0 0 0 0 4 1 0 0 0   0 0 1 4 0 1 a   7f
0 0 0 3 0 0 0 0 0 0   0 0 1 4 0 0 0   3f
0 0 0 0 1 0 0 0 0 0   0 0 1 4 0 0 0   3f
0 0 0 0 0 8 1 0 0 0   0 0 1 c 1 0 0   3f
0 0 0 0 0 0 0 0 0 0   0 0 1 c 0 0 0   3f
0 0 0 0 0 0 0 0 1 5   0 0 1 c 0 0 0   3f
0 0 8 0 0 0 0 0 0 0   0 0 1 c 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   0 0 1 c 0 0 0   3f
0 0 0 0 1 0 0 0 0 0   0 0 1 c 0 0 0   3f
0 0 0 0 0 1 1 0 0 0   0 0 1 d 1 0 0   3f
0 0 0 0 0 0 0 0 0 0   0 0 1 d 0 0 0   3f
0 0 0 0 0 0 0 0 0 7   0 0 1 d 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   0 0 1 1 0 0 0   3f
0 0 1 0 0 0 0 0 0 0   0 0 1 1 0 0 0   3f
0 0 0 0 0 0 0 0 0 0   0 0 1 1 0 1 7   7f
0 0 0 0 0 0 0 0 0 0   0 0 1 d 0 0 0   3f

/* rdmat_top.f */
verilog/rdmat_pkg.sv
verilog/rdmat_entry_ctl.sv
verilog/rdmat_hit_pipe.sv
verilog/rdmat_mbid_file.sv
verilog/rdmat_top.sv
bench/rdmat_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --assert --top-module rdmat_tb -f rdmat_top.f --Mdir obj_dir -o rdmat_sim
	./obj_dir/rdmat_sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
